/* la_capture.f */
verilog/la_pkg.sv
verilog/la_cfg_if.sv
verilog/la_regs.sv
verilog/la_trigger.sv
verilog/la_sampler.sv
verilog/logic_analyzer.sv
sim/la_chk.sv
sim/tb_logic_analyzer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the logic analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_logic_analyzer -f la_capture.f -o tb_logic_analyzer
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_logic_analyzer 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "TESTS PASSED"; then
   exit 0
fi
exit 1

/* sim/la_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module la_chk (
   input logic observer_clk,
   input logic reset,
   input logic fifo_wr,
   input logic capturing,
   input logic capture_start,
   input logic armed
);

   int unsigned fail_count = 0;   // Read by the testbench at the end

   // A word needs two samples, so writes never come back to back
   wr_spacing: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |=> !fifo_wr)
      else begin
         fail_count++;
         $error("fifo_wr high on two consecutive cycles");
      end

   wr_in_capture: assert property (@(posedge observer_clk) disable iff (reset)
      fifo_wr |-> capturing)
      else begin
         fail_count++;
         $error("fifo_wr high while not capturing");
      end

   // Arm drops soon after the capture has started
   arm_clear: assert property (@(posedge observer_clk) disable iff (reset)
      $past(capture_start, 2) |-> !armed)
      else begin
         fail_count++;
         $error("arm still set two cycles after capture_start");
      end

endmodule

`default_nettype wire

/* sim/tb_logic_analyzer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_logic_analyzer;

   localparam int wait_limit = 1000;  // Cycles per wait loop

   logic        observer_clk;
   logic        reset;
   logic [7:0]  reg_address;
   logic [6:0]  reg_bytecnt;
   logic [7:0]  reg_datai;
   logic [7:0]  reg_datao;
   logic        reg_read;
   logic        reg_write;
   logic [3:0]  io;
   logic [7:0]  userio;
   logic        hs1;
   logic        hs2;
   logic        aux_mcx;
   logic        trig_mcx;
   logic        adc_sample_clk;
   logic        userio_clk;
   logic        glitch_go;
   logic        capture_active;
   logic        fifo_wr;
   logic [17:0] fifo_wr_data;
   logic        fifo_flush;
   logic        fifo_empty;

   int errors   = 0;
   int timeouts = 0;
   int wr_total = 0;
   int wr_base  = 0;

   logic_analyzer DUT (.*);

   bind la_sampler la_chk u_chk (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .fifo_wr       (fifo_wr),
      .capturing     (capturing_q),
      .capture_start (capture_start_q),
      .armed         (tb_logic_analyzer.DUT.u_regs.arm_q)
   );

   initial begin
      observer_clk = 1'b0;
      forever #5 observer_clk = ~observer_clk;
   end

   always @(posedge observer_clk) begin
      if (fifo_wr)
         wr_total <= wr_total + 1;
   end

   // Held pins give equal older and newer samples per channel
   function automatic logic [17:0] dup_word(input logic [8:0] ch);
      logic [17:0] w;
      w = '0;
      for (int c = 0; c < 9; c++) begin
         w[2*c+1] = ch[c];
         w[2*c]   = ch[c];
      end
      return w;
   endfunction

   function automatic logic [8:0] io_group();
      return {adc_sample_clk, trig_mcx, aux_mcx, hs2, hs1, io};
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("Timed out waiting for %s", what);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [6:0] bcnt,
                            input logic [7:0] data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bcnt;
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge observer_clk);
      reg_write   <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [6:0] bcnt,
                           output logic [7:0] data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bcnt;
      reg_read    <= 1'b1;
      @(posedge observer_clk);
      data = reg_datao;   // Settled during the cycle
      reg_read <= 1'b0;
   endtask

   task automatic expect_reg(input logic [7:0] addr, input logic [6:0] bcnt,
                             input logic [7:0] exp, input string name);
      logic [7:0] v;
      read_reg(addr, bcnt, v);
      check_eq(name, 32'(v), 32'(exp));
   endtask

   task automatic randomize_pins();
      @(posedge observer_clk);
      io             <= 4'($urandom);
      userio         <= 8'($urandom);
      hs1            <= 1'($urandom);
      hs2            <= 1'($urandom);
      aux_mcx        <= 1'($urandom);
      trig_mcx       <= 1'($urandom);
      adc_sample_clk <= 1'($urandom);
      userio_clk     <= 1'($urandom);
   endtask

   task automatic setup_capture(input logic [2:0] group, input logic [15:0] depth,
                                input logic [15:0] ds);
      write_reg(la_pkg::addr_capture_group, 7'd0, 8'(group));
      write_reg(la_pkg::addr_capture_depth, 7'd0, depth[7:0]);
      write_reg(la_pkg::addr_capture_depth, 7'd1, depth[15:8]);
      write_reg(la_pkg::addr_downsample, 7'd0, ds[7:0]);
      write_reg(la_pkg::addr_downsample, 7'd1, ds[15:8]);
      wr_base = wr_total;
      write_reg(la_pkg::addr_arm, 7'd0, 8'h01);
   endtask

   // Collect n words and wait for the capture to end
   task automatic expect_capture(input int n, input logic [17:0] exp, input int gap);
      int         seen;
      int         cyc;
      int         last;
      logic [7:0] v;
      seen = 0;
      cyc  = 0;
      last = -1;
      while (seen < n && cyc < wait_limit) begin
         @(posedge observer_clk);
         cyc++;
         if (fifo_wr) begin
            check_eq("fifo_wr_data", 32'(fifo_wr_data), 32'(exp));
            if (gap > 0 && last >= 0)
               check_eq("fifo_wr spacing", 32'(cyc - last), 32'(gap));
            last = cyc;
            seen++;
         end
      end
      if (seen < n)
         note_timeout("capture words on fifo_wr");
      cyc = 0;
      v   = 8'hff;
      while (v[0] && cyc < wait_limit) begin
         read_reg(la_pkg::addr_status, 7'd0, v);
         cyc++;
      end
      if (v[0])
         note_timeout("capturing status to clear");
      check_eq("status", 32'(v), 32'h0);
      check_eq("fifo_wr count", 32'(wr_total - wr_base), 32'(n));
      expect_reg(la_pkg::addr_arm, 7'd0, 8'h00, "arm");
   endtask

   task automatic wait_flush(input logic level);
      int cyc;
      cyc = 0;
      while (fifo_flush !== level && cyc < wait_limit) begin
         @(posedge observer_clk);
         cyc++;
      end
      if (fifo_flush !== level)
         note_timeout(level ? "fifo_flush to rise" : "fifo_flush to fall");
   endtask

   initial begin
      void'($urandom(70));
      reset          <= 1'b1;
      reg_address    <= '0;
      reg_bytecnt    <= '0;
      reg_datai      <= '0;
      reg_read       <= 1'b0;
      reg_write      <= 1'b0;
      io             <= '0;
      userio         <= '0;
      hs1            <= 1'b0;
      hs2            <= 1'b0;
      aux_mcx        <= 1'b0;
      trig_mcx       <= 1'b0;
      adc_sample_clk <= 1'b0;
      userio_clk     <= 1'b0;
      glitch_go      <= 1'b0;
      capture_active <= 1'b0;
      fifo_empty     <= 1'b0;   // FIFO holds data through reset
      repeat (5) @(posedge observer_clk);
      reset <= 1'b0;

      // Reset state and readback
      expect_reg(la_pkg::addr_status, 7'd0, 8'h00, "status");
      check_eq("fifo_flush", 32'(fifo_flush), 32'h0);
      @(posedge observer_clk);
      fifo_empty <= 1'b1;   // Empty until the flush test
      write_reg(la_pkg::addr_capture_group, 7'd0, 8'h05);
      write_reg(la_pkg::addr_trigger_source, 7'd0, 8'h2a);
      write_reg(la_pkg::addr_capture_depth, 7'd0, 8'h34);
      write_reg(la_pkg::addr_capture_depth, 7'd1, 8'h12);
      write_reg(la_pkg::addr_downsample, 7'd0, 8'h56);
      write_reg(la_pkg::addr_downsample, 7'd1, 8'h07);
      expect_reg(la_pkg::addr_capture_group, 7'd0, 8'h05, "capture_group");
      expect_reg(la_pkg::addr_trigger_source, 7'd0, 8'h2a, "trigger_source");
      expect_reg(la_pkg::addr_capture_depth, 7'd0, 8'h34, "capture_depth[7:0]");
      expect_reg(la_pkg::addr_capture_depth, 7'd1, 8'h12, "capture_depth[15:8]");
      expect_reg(la_pkg::addr_downsample, 7'd0, 8'h56, "downsample[7:0]");
      expect_reg(la_pkg::addr_downsample, 7'd1, 8'h07, "downsample[15:8]");
      @(posedge observer_clk);
      reg_address <= la_pkg::addr_capture_group;
      reg_read    <= 1'b0;
      @(posedge observer_clk);
      check_eq("reg_datao", 32'(reg_datao), 32'h0);
      write_reg(la_pkg::addr_trigger_source, 7'd0, 8'(la_pkg::trig_glitch_go));

      // Manual capture on the io group and then the userio group
      randomize_pins();
      setup_capture(la_pkg::group_io, 16'd8, 16'd0);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h01);
      expect_capture(4, dup_word(io_group()), 2);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h00);
      randomize_pins();
      setup_capture(la_pkg::group_userio, 16'd6, 16'd0);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h01);
      expect_capture(3, dup_word({userio_clk, userio}), 2);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h00);

      // Unused group gives the alternating pattern
      setup_capture(3'd5, 16'd4, 16'd0);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h01);
      expect_capture(2, dup_word(9'h155), 2);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h00);

      // Inverted io2 fires on the falling pin
      @(posedge observer_clk);
      io <= 4'b0010;
      write_reg(la_pkg::addr_trigger_source, 7'd0, 8'h29);
      setup_capture(la_pkg::group_io, 16'd2, 16'd0);
      @(posedge observer_clk);
      io[1] <= 1'b0;
      @(posedge observer_clk);
      expect_capture(1, dup_word(io_group()), 0);

      // userio5 fires on the rising pin
      @(posedge observer_clk);
      userio[5] <= 1'b0;
      write_reg(la_pkg::addr_trigger_source, 7'd0, 8'h0d);
      setup_capture(la_pkg::group_userio, 16'd2, 16'd0);
      @(posedge observer_clk);
      userio[5] <= 1'b1;
      @(posedge observer_clk);
      expect_capture(1, dup_word({userio_clk, userio}), 0);

      // Not armed so an edge must not start anything
      write_reg(la_pkg::addr_arm, 7'd0, 8'h00);
      @(posedge observer_clk);
      userio[5] <= 1'b0;
      repeat (4) @(posedge observer_clk);
      wr_base = wr_total;
      userio[5] <= 1'b1;
      repeat (20) @(posedge observer_clk);
      check_eq("fifo_wr count", 32'(wr_total - wr_base), 32'h0);

      // Downsample 3 puts pulses 2*(3+1) apart
      write_reg(la_pkg::addr_trigger_source, 7'd0, 8'(la_pkg::trig_glitch_go));
      randomize_pins();
      setup_capture(la_pkg::group_io, 16'd6, 16'd3);
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h01);
      expect_capture(3, dup_word(io_group()), 2 * (3 + 1));
      write_reg(la_pkg::addr_manual_capture, 7'd0, 8'h00);

      // Flush on arm while the FIFO holds data
      @(posedge observer_clk);
      fifo_empty <= 1'b0;
      write_reg(la_pkg::addr_arm, 7'd0, 8'h01);
      wait_flush(1'b1);
      @(posedge observer_clk);
      fifo_empty <= 1'b1;
      wait_flush(1'b0);
      write_reg(la_pkg::addr_arm, 7'd0, 8'h00);

      $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, DUT.u_sampler.u_chk.fail_count);
      if (errors == 0 && timeouts == 0 && DUT.u_sampler.u_chk.fail_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/la_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface la_cfg_if;

   // Configuration from the register block
   logic [la_pkg::group_bits-1:0] capture_group;
   la_pkg::trig_src_u             trigger_source;
   logic                          manual_capture;
   logic [la_pkg::depth_bits-1:0] capture_depth;
   logic [la_pkg::depth_bits-1:0] downsample;
   logic                          armed;

   // Status back from the sampler
   logic capturing;
   logic capture_start;   // Delayed capture_go, clears arm

   modport regs (
      output capture_group, trigger_source, manual_capture,
      output capture_depth, downsample, armed,
      input  capturing, capture_start
   );

   modport sampler (
      input  capture_group, capture_depth, downsample,
      output capturing, capture_start
   );

   modport trigger (
      input trigger_source, manual_capture, armed, capturing
   );

endinterface

`default_nettype wire

/* verilog/la_pkg.sv */
`default_nettype none

package la_pkg;

   // Bus and datapath widths
   localparam int reg_addr_bits = 8;
   localparam int bytecnt_bits  = 7;
   localparam int depth_bits    = 16;
   localparam int channels      = 9;
   localparam int fifo_bits     = 18;  // Two samples per channel
   localparam int group_bits    = 3;

   // Register map
   localparam logic [reg_addr_bits-1:0] addr_capture_group  = 8'h00;
   localparam logic [reg_addr_bits-1:0] addr_trigger_source = 8'h02;
   localparam logic [reg_addr_bits-1:0] addr_status         = 8'h03;
   localparam logic [reg_addr_bits-1:0] addr_capture_depth  = 8'h05;
   localparam logic [reg_addr_bits-1:0] addr_downsample     = 8'h06;
   localparam logic [reg_addr_bits-1:0] addr_arm            = 8'h08;
   localparam logic [reg_addr_bits-1:0] addr_manual_capture = 8'h09;

   // Capture groups
   localparam logic [group_bits-1:0] group_io     = 3'd1;
   localparam logic [group_bits-1:0] group_userio = 3'd2;

   // Alternating pattern for unused groups
   localparam logic [channels-1:0] default_pattern = 9'b1_0101_0101;

   // Internal trigger codes
   localparam logic [5:0] trig_glitch_go      = 6'd0;
   localparam logic [5:0] trig_capture_active = 6'd1;
   localparam logic [5:0] trig_hs1            = 6'd3;

   typedef struct packed {
      logic       sel_io;     // Bit 5
      logic       spare_4;
      logic       invert;     // Bit 3
      logic       spare_2;
      logic [1:0] pin;        // io1 to io4
   } trig_io_t;

   typedef struct packed {
      logic       sel_io;     // Clear for userio
      logic       invert;     // Bit 4
      logic       sel_userio; // Bit 3
      logic [2:0] pin;        // userio0 to userio7
   } trig_userio_t;

   // One trigger-source word, three readings
   typedef union packed {
      logic [5:0]   raw;
      trig_io_t     io;
      trig_userio_t userio;
   } trig_src_u;

endpackage

`default_nettype wire

/* verilog/la_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module la_regs (
   input  logic                            observer_clk,
   input  logic                            reset,
   input  logic [la_pkg::reg_addr_bits-1:0] reg_address,
   input  logic [la_pkg::bytecnt_bits-1:0]  reg_bytecnt,
   input  logic [7:0]                      reg_datai,
   input  logic                            reg_read,
   input  logic                            reg_write,
   output logic [7:0]                      reg_datao,
   input  logic                            fifo_empty,
   output logic                            fifo_flush,
   la_cfg_if.regs                          cfg
);

   logic [la_pkg::group_bits-1:0] group_q;
   la_pkg::trig_src_u             trig_q;
   logic                          manual_q;
   logic [la_pkg::depth_bits-1:0] depth_q;
   logic [la_pkg::depth_bits-1:0] downsample_q;
   logic                          arm_q;

   logic       byte_valid;
   logic [3:0] byte_sel;   // Bit offset of the addressed byte

   // Multi-byte registers, LSB first
   assign byte_valid = int'(reg_bytecnt) < (la_pkg::depth_bits / 8);
   assign byte_sel   = {reg_bytecnt[0], 3'b000};

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         group_q      <= '0;
         trig_q.raw   <= la_pkg::trig_glitch_go;
         manual_q     <= 1'b0;
         depth_q      <= '0;
         downsample_q <= '0;
      end else if (reg_write) begin
         case (reg_address)
            la_pkg::addr_capture_group:  group_q <= reg_datai[la_pkg::group_bits-1:0];
            la_pkg::addr_trigger_source: trig_q.raw <= reg_datai[5:0];
            la_pkg::addr_manual_capture: manual_q <= reg_datai[0];
            la_pkg::addr_capture_depth: begin
               if (byte_valid)
                  depth_q[byte_sel +: 8] <= reg_datai;
            end
            la_pkg::addr_downsample: begin
               if (byte_valid)
                  downsample_q[byte_sel +: 8] <= reg_datai;
            end
            default: ;
         endcase
      end
   end

   // Arm is set by software, cleared once the capture has started
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         arm_q <= 1'b0;
      end else if (reg_write && (reg_address == la_pkg::addr_arm)) begin
         arm_q <= reg_datai[0];
      end else if (cfg.capture_start) begin
         arm_q <= 1'b0;
      end
   end

   // Drain stale data out of the FIFO when a new capture is armed
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         fifo_flush <= 1'b0;
      end else if (fifo_empty) begin
         fifo_flush <= 1'b0;
      end else if (arm_q && !fifo_flush) begin
         fifo_flush <= 1'b1;
      end
   end

   // Readback
   always_comb begin
      reg_datao = 8'h00;
      if (reg_read) begin
         case (reg_address)
            la_pkg::addr_capture_group:  reg_datao = 8'(group_q);
            la_pkg::addr_status:         reg_datao = {7'b0, cfg.capturing};
            la_pkg::addr_trigger_source: reg_datao = {2'b0, trig_q.raw};
            la_pkg::addr_manual_capture: reg_datao = {7'b0, manual_q};
            la_pkg::addr_arm:            reg_datao = {7'b0, arm_q};
            la_pkg::addr_capture_depth: begin
               if (byte_valid)
                  reg_datao = depth_q[byte_sel +: 8];
            end
            la_pkg::addr_downsample: begin
               if (byte_valid)
                  reg_datao = downsample_q[byte_sel +: 8];
            end
            default: reg_datao = 8'h00;
         endcase
      end
   end

   assign cfg.capture_group  = group_q;
   assign cfg.trigger_source = trig_q;
   assign cfg.manual_capture = manual_q;
   assign cfg.capture_depth  = depth_q;
   assign cfg.downsample     = downsample_q;
   assign cfg.armed          = arm_q;

endmodule

`default_nettype wire

/* verilog/la_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module la_sampler (
   input  logic                        observer_clk,
   input  logic                        reset,
   input  logic                        capture_go,
   input  logic [3:0]                  io,
   input  logic [7:0]                  userio,
   input  logic                        hs1,
   input  logic                        hs2,
   input  logic                        aux_mcx,
   input  logic                        trig_mcx,
   input  logic                        adc_sample_clk,
   input  logic                        userio_clk,
   la_cfg_if.sampler                   cfg,
   output logic                        fifo_wr,
   output logic [la_pkg::fifo_bits-1:0] fifo_wr_data
);

   logic [la_pkg::channels-1:0]        src_q;     // Registered group mux
   logic [la_pkg::channels-1:0][1:0]   shift_q;   // Older sample in bit 1
   logic [la_pkg::depth_bits-1:0]      count_q;
   logic [la_pkg::depth_bits-1:0]      ds_ctr_q;
   logic                               ds_en_q;
   logic                               capturing_q;
   logic                               capture_start_q;
   logic                               ticktock_q;
   logic                               sample_en;

   // Group select, one register stage on the pins
   always_ff @(posedge observer_clk) begin
      case (cfg.capture_group)
         la_pkg::group_io:
            src_q <= {adc_sample_clk, trig_mcx, aux_mcx, hs2, hs1, io};
         la_pkg::group_userio:
            src_q <= {userio_clk, userio};
         default:
            src_q <= la_pkg::default_pattern;
      endcase
   end

   // Sample strobe every downsample+1 cycles, phase set by capture_go
   always_ff @(posedge observer_clk) begin
      if (reset || capture_go) begin
         ds_ctr_q <= '0;
         ds_en_q  <= 1'b0;
      end else if (ds_ctr_q == cfg.downsample) begin
         ds_ctr_q <= '0;
         ds_en_q  <= 1'b1;
      end else begin
         ds_ctr_q <= ds_ctr_q + 1'b1;
         ds_en_q  <= 1'b0;
      end
   end

   assign sample_en = capturing_q && ds_en_q && (count_q != cfg.capture_depth);

   // Capture sequencer
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         count_q         <= '0;
         capturing_q     <= 1'b0;
         capture_start_q <= 1'b0;
         ticktock_q      <= 1'b0;
         fifo_wr         <= 1'b0;
      end else begin
         capture_start_q <= capture_go;
         fifo_wr         <= 1'b0;
         if (capture_go) begin
            count_q     <= '0;
            capturing_q <= 1'b1;
            ticktock_q  <= 1'b0;
         end else if (sample_en) begin
            count_q    <= count_q + 1'b1;
            ticktock_q <= ~ticktock_q;
            fifo_wr    <= ticktock_q;  // Second sample of a pair
         end else if (capturing_q && (count_q == cfg.capture_depth)) begin
            // Stays high through the last write pulse
            capturing_q <= 1'b0;
         end
      end
   end

   // Two-deep shift per channel
   always_ff @(posedge observer_clk) begin
      if (sample_en) begin
         for (int c = 0; c < la_pkg::channels; c++) begin
            shift_q[c] <= {shift_q[c][0], src_q[c]};
         end
      end
   end

   assign fifo_wr_data      = shift_q;
   assign cfg.capturing     = capturing_q;
   assign cfg.capture_start = capture_start_q;

endmodule

`default_nettype wire

/* verilog/la_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module la_trigger (
   input  logic       observer_clk,
   input  logic       reset,
   input  logic [3:0] io,
   input  logic [7:0] userio,
   input  logic       hs1,
   input  logic       glitch_go,
   input  logic       capture_active,
   la_cfg_if.trigger  cfg,
   output logic       capture_go
);

   la_pkg::trig_src_u ts;
   logic              src_sel;
   logic              go_async;
   logic [1:0]        sync_q;   // Pins are asynchronous
   logic              edge_q;

   assign ts = cfg.trigger_source;

   // Source decode
   always_comb begin
      src_sel = 1'b0;
      if (ts.io.sel_io) begin
         src_sel = io[ts.io.pin] ^ ts.io.invert;
      end else if (ts.userio.sel_userio) begin
         src_sel = userio[ts.userio.pin] ^ ts.userio.invert;
      end else begin
         case (ts.raw)
            la_pkg::trig_glitch_go:      src_sel = glitch_go;
            la_pkg::trig_capture_active: src_sel = capture_active;
            la_pkg::trig_hs1:            src_sel = hs1;
            default:                     src_sel = 1'b0;  // Unused code
         endcase
      end
   end

   // Software trigger overrides the selected source
   assign go_async = src_sel | cfg.manual_capture;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_q <= 2'b00;
         edge_q <= 1'b0;
      end else begin
         sync_q <= {sync_q[0], go_async};
         edge_q <= sync_q[1];
      end
   end

   // Rising edge only while armed and idle, so a held source
   // cannot restart a capture in progress
   assign capture_go = sync_q[1] & ~edge_q & cfg.armed & ~cfg.capturing;

endmodule

`default_nettype wire

/* verilog/logic_analyzer.sv */
`timescale 1ns/1ps
`default_nettype none

module logic_analyzer (
   input  logic        observer_clk,
   input  logic        reset,

   // Register port
   input  logic [7:0]  reg_address,
   input  logic [6:0]  reg_bytecnt,
   input  logic [7:0]  reg_datai,
   output logic [7:0]  reg_datao,
   input  logic        reg_read,
   input  logic        reg_write,

   // Pins
   input  logic [3:0]  io,
   input  logic [7:0]  userio,
   input  logic        hs1,
   input  logic        hs2,
   input  logic        aux_mcx,
   input  logic        trig_mcx,
   input  logic        adc_sample_clk,
   input  logic        userio_clk,
   input  logic        glitch_go,
   input  logic        capture_active,

   // FIFO write side
   output logic        fifo_wr,
   output logic [17:0] fifo_wr_data,
   output logic        fifo_flush,
   input  logic        fifo_empty
);

   logic capture_go;

   la_cfg_if cfg ();

   la_regs u_regs (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_address  (reg_address),
      .reg_bytecnt  (reg_bytecnt),
      .reg_datai    (reg_datai),
      .reg_read     (reg_read),
      .reg_write    (reg_write),
      .reg_datao    (reg_datao),
      .fifo_empty   (fifo_empty),
      .fifo_flush   (fifo_flush),
      .cfg          (cfg.regs)
   );

   la_trigger u_trigger (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .io             (io),
      .userio         (userio),
      .hs1            (hs1),
      .glitch_go      (glitch_go),
      .capture_active (capture_active),
      .cfg            (cfg.trigger),
      .capture_go     (capture_go)
   );

   la_sampler u_sampler (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .capture_go     (capture_go),
      .io             (io),
      .userio         (userio),
      .hs1            (hs1),
      .hs2            (hs2),
      .aux_mcx        (aux_mcx),
      .trig_mcx       (trig_mcx),
      .adc_sample_clk (adc_sample_clk),
      .userio_clk     (userio_clk),
      .cfg            (cfg.sampler),
      .fifo_wr        (fifo_wr),
      .fifo_wr_data   (fifo_wr_data)
   );

endmodule

`default_nettype wire
